// File: verilog.f
hw/fp_fmt_pkg.sv
hw/noncomp_pkg.sv
hw/fp_classifier.sv
hw/sign_injector.sv
hw/fp_comparator.sv
hw/noncomp_ctrl.sv
hw/pipe_regs.sv
hw/fp_noncomp.sv
bench/tb_clk_gen.sv
bench/tb_fp_noncomp.sv

// File: Bender.yml
package:
  name: fp_noncomp

sources:
  - hw/fp_fmt_pkg.sv
  - hw/noncomp_pkg.sv
  - hw/fp_classifier.sv
  - hw/sign_injector.sv
  - hw/fp_comparator.sv
  - hw/noncomp_ctrl.sv
  - hw/pipe_regs.sv
  - hw/fp_noncomp.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_fp_noncomp.sv

// File: bench/tb_fp_noncomp.sv
`timescale 1ns/100ps

module tb_fp_noncomp;

  typedef logic [15:0] tag_t;

  // Expected item, kept in acceptance order
  typedef struct {
    noncomp_pkg::result_t res;
    tag_t                 tag;
    int                   test;
  } exp_t;

  localparam int LATENCY      = 2;
  localparam int N_SPEC       = 12;
  localparam int N_BP         = 200;
  localparam int N_FLUSHED    = 2;
  localparam int N_AFTER      = 8;
  // Sign injection, min/max plus compare, classify, back-pressure, flush
  localparam int N_REQ        = 8 * N_SPEC + 8 * N_SPEC * N_SPEC + 2 * N_SPEC + N_BP +
                                N_FLUSHED + N_AFTER;
  localparam int RESET_CYCLES = 8;
  localparam int STALL_CYCLES = 32;
  localparam int TIMEOUT      = 4 * N_REQ + RESET_CYCLES + STALL_CYCLES;
  localparam int ITEM_W       = $bits(tag_t) + $bits(noncomp_pkg::result_t);

  logic                         clk_i;
  logic                         rst_i;
  fp_fmt_pkg::fp_t        [1:0] operands_i;
  noncomp_pkg::op_e             op_i;
  noncomp_pkg::subop_e          subop_i;
  logic                         op_mod_i;
  tag_t                         tag_i;
  logic                         in_valid_i;
  logic                         in_ready_o;
  logic                         flush_i;
  fp_fmt_pkg::fp_t              result_o;
  fp_fmt_pkg::status_t          status_o;
  logic                         extension_bit_o;
  fp_fmt_pkg::classmask_e       class_mask_o;
  logic                         is_class_o;
  tag_t                         tag_o;
  logic                         out_valid_o;
  logic                         out_ready_i;
  logic                         busy_o;

  integer              seed = 52;
  exp_t                exp_q [$];
  logic [ITEM_W-1:0]   exp_item;
  logic [ITEM_W-1:0]   act_item;
  int                  exp_test = 0;
  logic                exp_avail = 1'b0;
  tag_t                tag_floor = '0;
  tag_t                next_tag = '0;
  int                  cur_test = 0;
  int                  ready_mode = 0;
  logic                lat_check = 1'b0;
  logic                took;
  int                  cycle_count = 0;
  int                  out_count = 0;

  // Zeros, normals, infinities, subnormals, quiet and signalling NaNs
  logic [31:0] specials [N_SPEC] = '{
    32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'hBF80_0000,
    32'hFF7F_FFFF, 32'h7F80_0000, 32'hFF80_0000, 32'h0000_0001,
    32'h807F_FFFF, 32'h7FC0_0000, 32'hFFC1_2345, 32'h7F80_0001
  };

  string test_names [7] = '{"reset", "sign injection", "min/max", "compare", "classify",
                            "back-pressure", "flush"};

  tb_clk_gen #(.RESET_CYCLES(RESET_CYCLES)) i_clk_gen (.clk_o(clk_i), .rst_o(rst_i));

  fp_noncomp #(
    .NUM_INP_REGS (1),
    .NUM_OUT_REGS (1),
    .tag_t        (tag_t)
  ) uut (
    .clk_i, .rst_i, .operands_i, .op_i, .subop_i, .op_mod_i, .tag_i,
    .in_valid_i, .in_ready_o, .flush_i,
    .result_o, .status_o, .extension_bit_o, .class_mask_o, .is_class_o, .tag_o,
    .out_valid_o, .out_ready_i, .busy_o
  );

  assign act_item = {tag_o, result_o, status_o, extension_bit_o, class_mask_o, is_class_o};

  // ---------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------

  function automatic logic is_nan_f(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != '0);
  endfunction

  // One-hot index: -inf, -norm, -sub, -0, +0, +sub, +norm, +inf, sNaN, qNaN
  function automatic logic [9:0] class_of(input logic [31:0] x);
    int idx;
    if (is_nan_f(x)) idx = x[22] ? 9 : 8;
    else if (x[30:23] == 8'hFF) idx = x[31] ? 0 : 7;
    else if (x[30:0] == '0) idx = x[31] ? 3 : 4;
    else if (x[30:23] == '0) idx = x[31] ? 2 : 5;
    else idx = x[31] ? 1 : 6;
    return 10'b1 << idx;
  endfunction

  // Signed order key; -0 sits below +0 unless zeros compare equal
  function automatic longint key_of(input logic [31:0] x, input logic zeros_equal);
    longint mag;
    mag = longint'(x[30:0]);
    if (!x[31]) return mag;
    if (zeros_equal) return -mag;
    return -mag - 1;
  endfunction

  function automatic noncomp_pkg::result_t model(input logic [31:0] a, input logic [31:0] b,
      input noncomp_pkg::op_e op, input noncomp_pkg::subop_e sub, input logic m);
    noncomp_pkg::result_t res;
    logic                 any_nan;
    logic                 any_snan;
    logic                 sgn;
    logic                 c;
    longint               ka;
    longint               kb;
    res = '0;
    // Class mask of A travels with every op
    res.class_mask = fp_fmt_pkg::classmask_e'(class_of(a));
    any_nan  = is_nan_f(a) || is_nan_f(b);
    any_snan = (is_nan_f(a) && !a[22]) || (is_nan_f(b) && !b[22]);
    case (op)
      noncomp_pkg::SGNJ: begin
        case (sub)
          noncomp_pkg::RNE: sgn = b[31];
          noncomp_pkg::RTZ: sgn = !b[31];
          noncomp_pkg::RDN: sgn = a[31] ^ b[31];
          default:          sgn = a[31];
        endcase
        res.result        = {sgn, a[30:0]};
        res.extension_bit = m ? sgn : 1'b1;
      end
      noncomp_pkg::MINMAX: begin
        ka = key_of(a, 1'b0);
        kb = key_of(b, 1'b0);
        res.status.NV     = any_snan;
        res.extension_bit = 1'b1;
        if (is_nan_f(a) && is_nan_f(b)) res.result = 32'h7FC0_0000;
        else if (is_nan_f(a)) res.result = b;
        else if (is_nan_f(b)) res.result = a;
        else if (sub == noncomp_pkg::RTZ) res.result = (ka < kb) ? b : a;
        else res.result = (ka < kb) ? a : b;
      end
      noncomp_pkg::CMP: begin
        ka = key_of(a, 1'b1);
        kb = key_of(b, 1'b1);
        // LE and LT signal on any NaN, EQ only on sNaN
        if (any_snan || (any_nan && sub != noncomp_pkg::RDN)) begin
          res.status.NV = 1'b1;
          c = 1'b0;
        end else if (any_nan) begin
          c = m;
        end else begin
          case (sub)
            noncomp_pkg::RNE: c = (ka <= kb);
            noncomp_pkg::RTZ: c = (ka < kb);
            default:          c = (ka == kb);
          endcase
          c = c ^ m;
        end
        res.result = {31'b0, c};
      end
      default: begin
        res.is_class = 1'b1;
      end
    endcase
    return res;
  endfunction

  // ---------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------

  // Mostly raw random bits, one in four from the special table
  function automatic logic [31:0] rand_operand();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:0] < 4) return specials[r[11:4] % N_SPEC];
    return $random(seed);
  endfunction

  // Sub-operation that exists for the given op
  function automatic noncomp_pkg::subop_e legal_subop(input logic [31:0] r);
    case (r[1:0])
      2'd0:    return noncomp_pkg::subop_e'({1'b0, r[6:5]});
      2'd1:    return noncomp_pkg::subop_e'({2'b0, r[5]});
      2'd2:    return noncomp_pkg::subop_e'({1'b0, r[6:5] % 2'd3});
      default: return noncomp_pkg::RNE;
    endcase
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  // Edge, note acceptance, then drive 1 ns later
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk_i);
    took = in_valid_i && in_ready_o;
    #1;
    r = $random(seed);
    case (ready_mode)
      0:       out_ready_i = 1'b1;
      1:       out_ready_i = r[0];
      default: out_ready_i = 1'b0;
    endcase
  endtask

  task automatic send(input logic [31:0] a, input logic [31:0] b,
      input noncomp_pkg::op_e op, input noncomp_pkg::subop_e sub, input logic mod);
    operands_i[0] = a;
    operands_i[1] = b;
    op_i          = op;
    subop_i       = sub;
    op_mod_i      = mod;
    tag_i         = next_tag;
    in_valid_i    = 1'b1;
    next_cycle();
    while (!took) next_cycle();
    in_valid_i = 1'b0;
    next_tag++;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || busy_o) next_cycle();
  endtask

  // ---------------------------------------------------------------------
  // Scoreboard queue and timeout
  // ---------------------------------------------------------------------

  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_q.delete();
    end else begin
      if (out_valid_o && out_ready_i && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        out_count++;
      end
      if (in_valid_i && in_ready_o && !flush_i) begin
        exp_q.push_back('{res: model(operands_i[0], operands_i[1], op_i, subop_i, op_mod_i),
                          tag: tag_i, test: cur_test});
      end
      // Flushed items must never come out
      if (flush_i) begin
        exp_q.delete();
        tag_floor <= next_tag;
      end
    end
    exp_avail <= (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      exp_item <= {exp_q[0].tag, exp_q[0].res};
      exp_test <= exp_q[0].test;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT)
      fail_run($sformatf("Timeout: run still going after %0d cycles", cycle_count));
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  reset_a: assert property (@(posedge clk_i)
    $fell(rst_i) |-> in_ready_o && !busy_o && !out_valid_o)
    else fail_run("Handshake state wrong right after reset");

  order_a: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i |-> exp_avail)
    else fail_run("Output delivered with no request outstanding");

  // Tag and whole result against the queue head
  match_a: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i && exp_avail |-> act_item == exp_item)
    else fail_run($sformatf("Error: %s: tag+result expected %h, actual %h",
      test_names[$sampled(exp_test)], $sampled(exp_item), $sampled(act_item)));

  hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(act_item))
    else fail_run("Output changed or dropped while stalled");

  flush_a: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_i |=> !busy_o && !out_valid_o)
    else fail_run("Pipeline not empty in the cycle after a flush");

  floor_a: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o |-> tag_o >= tag_floor)
    else fail_run($sformatf("Error: %s: tag at least %h expected, actual %h",
      test_names[cur_test], $sampled(tag_floor), $sampled(tag_o)));

  // Free-flowing output, so latency is fixed
  latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i && in_ready_o && lat_check |->
      ##LATENCY out_valid_o && tag_o == $past(tag_i, LATENCY))
    else fail_run($sformatf("Error: %s: tag %h expected after %0d cycles, actual %h",
      test_names[cur_test], $past(tag_i, LATENCY), LATENCY, $sampled(tag_o)));

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------

  initial begin
    int          s;
    int          m;
    int          i;
    int          j;
    logic [31:0] r;
    operands_i  = '0;
    op_i        = noncomp_pkg::SGNJ;
    subop_i     = noncomp_pkg::RNE;
    op_mod_i    = 1'b0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    @(negedge rst_i);

    cur_test  = 1;
    lat_check = 1'b1;
    for (s = 0; s < 4; s++)
      for (m = 0; m < 2; m++)
        for (i = 0; i < N_SPEC; i++)
          send(specials[i], rand_operand(), noncomp_pkg::SGNJ, noncomp_pkg::subop_e'(s), m[0]);
    drain();

    // Every ordered pair of specials, min then max
    cur_test = 2;
    for (s = 0; s < 2; s++)
      for (i = 0; i < N_SPEC; i++)
        for (j = 0; j < N_SPEC; j++)
          send(specials[i], specials[j], noncomp_pkg::MINMAX, noncomp_pkg::subop_e'(s), 1'b0);
    drain();

    // LE, LT, EQ with and without inversion
    cur_test = 3;
    for (s = 0; s < 3; s++)
      for (m = 0; m < 2; m++)
        for (i = 0; i < N_SPEC; i++)
          for (j = 0; j < N_SPEC; j++)
            send(specials[i], specials[j], noncomp_pkg::CMP, noncomp_pkg::subop_e'(s), m[0]);
    drain();

    // All ten classes from the table, then random bits
    cur_test = 4;
    for (i = 0; i < N_SPEC; i++)
      send(specials[i], '0, noncomp_pkg::CLASSIFY, noncomp_pkg::RNE, 1'b0);
    for (i = 0; i < N_SPEC; i++)
      send(rand_operand(), rand_operand(), noncomp_pkg::CLASSIFY, noncomp_pkg::RNE, 1'b0);
    drain();

    // Random ops with a randomly stalling consumer
    cur_test   = 5;
    lat_check  = 1'b0;
    ready_mode = 1;
    for (i = 0; i < N_BP; i++) begin
      r = $random(seed);
      send(rand_operand(), rand_operand(), noncomp_pkg::op_e'(r[1:0]), legal_subop(r), r[4]);
    end
    drain();

    // Fill both stages behind a stalled output, flush, then resume
    cur_test    = 6;
    ready_mode  = 2;
    out_ready_i = 1'b0;
    for (i = 0; i < N_FLUSHED; i++)
      send(rand_operand(), rand_operand(), noncomp_pkg::CLASSIFY, noncomp_pkg::RNE, 1'b0);
    flush_i = 1'b1;
    next_cycle();
    flush_i     = 1'b0;
    ready_mode  = 0;
    out_ready_i = 1'b1;
    lat_check   = 1'b1;
    for (i = 0; i < N_AFTER; i++)
      send(specials[i], specials[N_SPEC-1-i], noncomp_pkg::MINMAX, noncomp_pkg::RTZ, 1'b0);
    drain();

    if (exp_q.size() == 0 && out_count == N_REQ - N_FLUSHED) begin
      $display("All tests passed!");
      $finish;
    end else begin
      fail_run($sformatf("Error: end of run: outputs expected %0d, actual %0d",
        N_REQ - N_FLUSHED, out_count));
    end
  end

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset high over the first edges, released just after the last one
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// File: hw/fp_noncomp.sv
`timescale 1ns/100ps

module fp_noncomp #(
  parameter int unsigned NUM_INP_REGS = 1,
  parameter int unsigned NUM_OUT_REGS = 1,
  parameter type         tag_t        = logic [3:0]
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Request
  input  fp_fmt_pkg::fp_t        [1:0] operands_i,
  input  noncomp_pkg::op_e             op_i,
  input  noncomp_pkg::subop_e          subop_i,
  input  logic                         op_mod_i,
  input  tag_t                         tag_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         flush_i,
  // Result
  output fp_fmt_pkg::fp_t              result_o,
  output fp_fmt_pkg::status_t          status_o,
  output logic                         extension_bit_o,
  output fp_fmt_pkg::classmask_e       class_mask_o,
  output logic                         is_class_o,
  output tag_t                         tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic                         busy_o
);

  typedef struct packed {
    fp_fmt_pkg::fp_t [1:0] operands;
    noncomp_pkg::op_e      op;
    noncomp_pkg::subop_e   subop;
    logic                  op_mod;
    tag_t                  tag;
  } inp_payload_t;

  typedef struct packed {
    noncomp_pkg::result_t res;
    tag_t                 tag;
  } out_payload_t;

  inp_payload_t                 inp_d, mid;
  out_payload_t                 out_d, out_q;
  logic                         mid_valid, mid_ready;
  logic                         inp_busy, out_busy;
  noncomp_pkg::func_t           func;
  fp_fmt_pkg::fp_info_t   [1:0] info;
  fp_fmt_pkg::classmask_e       class_mask;
  fp_fmt_pkg::fp_t              sgnj_res, minmax_res;
  fp_fmt_pkg::status_t          minmax_status, cmp_status;
  logic                         sgnj_ext, cmp_bit;

  assign inp_d = '{operands: operands_i, op: op_i, subop: subop_i, op_mod: op_mod_i, tag: tag_i};

  // ---------------------------------------------------------------------
  // Input pipeline
  // ---------------------------------------------------------------------

  pipe_regs #(.payload_t(inp_payload_t), .NUM_REGS(NUM_INP_REGS)) i_inp_pipe (
    .clk_i, .rst_i, .flush_i,
    .data_i (inp_d), .valid_i (in_valid_i), .ready_o (in_ready_o),
    .data_o (mid), .valid_o (mid_valid), .ready_i (mid_ready),
    .busy_o (inp_busy)
  );

  // ---------------------------------------------------------------------
  // Datapaths and control
  // ---------------------------------------------------------------------

  fp_classifier i_classifier (
    .operands_i (mid.operands), .info_o (info), .class_mask_o (class_mask)
  );

  sign_injector i_sgnj (
    .operands_i (mid.operands), .sgnj_sel_i (func.sgnj_sel), .ext_sign_i (func.ext_sign),
    .result_o (sgnj_res), .extension_bit_o (sgnj_ext)
  );

  fp_comparator i_cmp (
    .operands_i (mid.operands), .info_i (info), .is_max_i (func.is_max),
    .cmp_sel_i (func.cmp_sel), .invert_i (func.invert),
    .minmax_o (minmax_res), .minmax_status_o (minmax_status),
    .cmp_bit_o (cmp_bit), .cmp_status_o (cmp_status)
  );

  noncomp_ctrl i_ctrl (
    .clk_i, .rst_i, .valid_i (mid_valid),
    .op_i (mid.op), .subop_i (mid.subop), .op_mod_i (mid.op_mod), .func_o (func),
    .sgnj_i (sgnj_res), .sgnj_ext_i (sgnj_ext),
    .minmax_i (minmax_res), .minmax_status_i (minmax_status),
    .cmp_bit_i (cmp_bit), .cmp_status_i (cmp_status),
    .class_mask_i (class_mask), .result_o (out_d.res)
  );

  assign out_d.tag = mid.tag;

  // ---------------------------------------------------------------------
  // Output pipeline
  // ---------------------------------------------------------------------

  pipe_regs #(.payload_t(out_payload_t), .NUM_REGS(NUM_OUT_REGS)) i_out_pipe (
    .clk_i, .rst_i, .flush_i,
    .data_i (out_d), .valid_i (mid_valid), .ready_o (mid_ready),
    .data_o (out_q), .valid_o (out_valid_o), .ready_i (out_ready_i),
    .busy_o (out_busy)
  );

  assign result_o        = out_q.res.result;
  assign status_o        = out_q.res.status;
  assign extension_bit_o = out_q.res.extension_bit;
  assign class_mask_o    = out_q.res.class_mask;
  assign is_class_o      = out_q.res.is_class;
  assign tag_o           = out_q.tag;
  assign busy_o          = inp_busy | out_busy;

endmodule

// File: hw/pipe_regs.sv
`timescale 1ns/100ps

module pipe_regs #(
  parameter type         payload_t = logic,
  parameter int unsigned NUM_REGS  = 1
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i,
  output logic     busy_o
);

  // Index i is the item after i stages
  payload_t              data  [NUM_REGS+1];
  logic     [NUM_REGS:0] valid;
  logic     [NUM_REGS:0] ready;

  assign data[0]         = data_i;
  assign valid[0]        = valid_i;
  assign ready_o         = ready[0];
  assign ready[NUM_REGS] = ready_i;

  // ---------------------------------------------------------------------
  // Register stages
  // ---------------------------------------------------------------------

  for (genvar i = 0; i < NUM_REGS; i++) begin : gen_stage
    logic     valid_q;
    payload_t data_q;

    // Advance when the next stage takes the item or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid[i+1];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_q <= 1'b0;
      end else if (ready[i]) begin
        valid_q <= valid[i];
      end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk_i) begin
      if (ready[i] && valid[i]) begin
        data_q <= data[i];
      end
    end

    assign valid[i+1] = valid_q;
    assign data[i+1]  = data_q;
  end

  assign data_o  = data[NUM_REGS];
  assign valid_o = valid[NUM_REGS];
  // Stage bits only, input valid does not count
  assign busy_o  = |(valid >> 1);

  if (NUM_REGS > 0) begin : gen_checks
    // Stalled item holds still until taken
    hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i && !flush_i |=> valid_o && $stable(data_o));
    // Flush empties every stage at once
    flush_a: assert property (@(posedge clk_i) disable iff (rst_i)
      flush_i |=> !busy_o);
  end

endmodule

// File: hw/noncomp_ctrl.sv
`timescale 1ns/100ps

module noncomp_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   valid_i,
  input  noncomp_pkg::op_e       op_i,
  input  noncomp_pkg::subop_e    subop_i,
  input  logic                   op_mod_i,
  output noncomp_pkg::func_t     func_o,
  input  fp_fmt_pkg::fp_t        sgnj_i,
  input  logic                   sgnj_ext_i,
  input  fp_fmt_pkg::fp_t        minmax_i,
  input  fp_fmt_pkg::status_t    minmax_status_i,
  input  logic                   cmp_bit_i,
  input  fp_fmt_pkg::status_t    cmp_status_i,
  input  fp_fmt_pkg::classmask_e class_mask_i,
  output noncomp_pkg::result_t   result_o
);

  // ---------------------------------------------------------------------
  // Sub-operation decode
  // ---------------------------------------------------------------------

  always_comb begin
    func_o          = '0;
    func_o.is_max   = (subop_i == noncomp_pkg::RTZ);
    func_o.invert   = op_mod_i;
    func_o.ext_sign = op_mod_i;
    unique case (subop_i)
      noncomp_pkg::RNE: begin
        func_o.sgnj_sel = noncomp_pkg::SEL_SGNJ;
        func_o.cmp_sel  = noncomp_pkg::CMP_LE;
      end
      noncomp_pkg::RTZ: begin
        func_o.sgnj_sel = noncomp_pkg::SEL_SGNJN;
        func_o.cmp_sel  = noncomp_pkg::CMP_LT;
      end
      noncomp_pkg::RDN: begin
        func_o.sgnj_sel = noncomp_pkg::SEL_SGNJX;
        func_o.cmp_sel  = noncomp_pkg::CMP_EQ;
      end
      default: begin
        func_o.sgnj_sel = noncomp_pkg::SEL_PASS;
        func_o.cmp_sel  = noncomp_pkg::CMP_EQ;
      end
    endcase
  end

  // ---------------------------------------------------------------------
  // Result select
  // ---------------------------------------------------------------------

  always_comb begin
    // Class mask always travels, is_class tells whether it counts
    result_o            = '0;
    result_o.class_mask = class_mask_i;
    unique case (op_i)
      noncomp_pkg::SGNJ: begin
        result_o.result        = sgnj_i;
        result_o.extension_bit = sgnj_ext_i;
      end
      noncomp_pkg::MINMAX: begin
        result_o.result        = minmax_i;
        result_o.status        = minmax_status_i;
        result_o.extension_bit = 1'b1;
      end
      noncomp_pkg::CMP: begin
        // Boolean lands in bit 0 of an integer register
        result_o.result = fp_fmt_pkg::fp_t'({{(fp_fmt_pkg::FP_WIDTH-1){1'b0}}, cmp_bit_i});
        result_o.status = cmp_status_i;
      end
      default: begin
        result_o.is_class = 1'b1;
      end
    endcase
  end

  // Sub-op must exist for the op that is actually presented
  subop_legal_a: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i |-> (op_i == noncomp_pkg::CLASSIFY) ||
                (subop_i inside {noncomp_pkg::RNE, noncomp_pkg::RTZ}) ||
                (subop_i == noncomp_pkg::RDN && op_i != noncomp_pkg::MINMAX) ||
                (subop_i == noncomp_pkg::RUP && op_i == noncomp_pkg::SGNJ));

endmodule

// File: hw/fp_comparator.sv
`timescale 1ns/100ps

module fp_comparator (
  input  fp_fmt_pkg::fp_t      [1:0] operands_i,
  input  fp_fmt_pkg::fp_info_t [1:0] info_i,
  input  logic                       is_max_i,
  input  noncomp_pkg::cmp_sel_e      cmp_sel_i,
  input  logic                       invert_i,
  output fp_fmt_pkg::fp_t            minmax_o,
  output fp_fmt_pkg::status_t        minmax_status_o,
  output logic                       cmp_bit_o,
  output fp_fmt_pkg::status_t        cmp_status_o
);

  fp_fmt_pkg::fp_t a;
  fp_fmt_pkg::fp_t b;
  logic            any_nan;
  logic            any_snan;
  logic            equal;
  logic            a_smaller;

  assign a = operands_i[0];
  assign b = operands_i[1];

  assign any_nan  = info_i[0].is_nan | info_i[1].is_nan;
  assign any_snan = info_i[0].is_signalling | info_i[1].is_signalling;

  // ---------------------------------------------------------------------
  // Shared magnitude and sign compare
  // ---------------------------------------------------------------------

  // +0 and -0 count as equal
  assign equal = (a == b) || (info_i[0].is_zero && info_i[1].is_zero);
  // Sign-magnitude order flips the unsigned result once a sign is set
  assign a_smaller = (a < b) ^ (a.sign || b.sign);

  // Min/max, quiet compare so only sNaN is invalid
  always_comb begin
    minmax_status_o    = '0;
    minmax_status_o.NV = any_snan;
    if (info_i[0].is_nan && info_i[1].is_nan) begin
      minmax_o = fp_fmt_pkg::CANON_NAN;
    end else if (info_i[0].is_nan) begin
      minmax_o = b;
    end else if (info_i[1].is_nan) begin
      minmax_o = a;
    end else if (is_max_i) begin
      minmax_o = a_smaller ? b : a;
    end else begin
      minmax_o = a_smaller ? a : b;
    end
  end

  // Compare, LE and LT are signalling, EQ is quiet
  always_comb begin
    cmp_bit_o    = 1'b0;
    cmp_status_o = '0;
    if (any_snan) begin
      cmp_status_o.NV = 1'b1;
    end else begin
      unique case (cmp_sel_i)
        noncomp_pkg::CMP_LE: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else cmp_bit_o = (a_smaller | equal) ^ invert_i;
        end
        noncomp_pkg::CMP_LT: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else cmp_bit_o = (a_smaller & ~equal) ^ invert_i;
        end
        noncomp_pkg::CMP_EQ: begin
          // NaN is never equal
          cmp_bit_o = any_nan ? invert_i : (equal ^ invert_i);
        end
        default: cmp_bit_o = 1'b0;
      endcase
    end
  end

endmodule

// File: hw/sign_injector.sv
`timescale 1ns/100ps

module sign_injector (
  input  fp_fmt_pkg::fp_t [1:0]  operands_i,
  input  noncomp_pkg::sgnj_sel_e sgnj_sel_i,
  input  logic                   ext_sign_i,
  output fp_fmt_pkg::fp_t        result_o,
  output logic                   extension_bit_o
);

  logic sign_a;
  logic sign_b;

  // Every operand treated as properly boxed
  assign sign_a = operands_i[0].sign;
  assign sign_b = operands_i[1].sign;

  // ---------------------------------------------------------------------
  // Sign replacement
  // ---------------------------------------------------------------------

  always_comb begin
    // Exponent and mantissa always come from A
    result_o = operands_i[0];
    unique case (sgnj_sel_i)
      noncomp_pkg::SEL_SGNJ:  result_o.sign = sign_b;
      noncomp_pkg::SEL_SGNJN: result_o.sign = ~sign_b;
      noncomp_pkg::SEL_SGNJX: result_o.sign = sign_a ^ sign_b;
      default:                result_o.sign = sign_a;
    endcase
  end

  // Integer sign extension only on request, else NaN-box with ones
  assign extension_bit_o = ext_sign_i ? result_o.sign : 1'b1;

endmodule

// File: hw/fp_classifier.sv
`timescale 1ns/100ps

module fp_classifier (
  input  fp_fmt_pkg::fp_t    [1:0] operands_i,
  output fp_fmt_pkg::fp_info_t [1:0] info_o,
  output fp_fmt_pkg::classmask_e   class_mask_o
);

  // ---------------------------------------------------------------------
  // Per-operand class bits
  // ---------------------------------------------------------------------

  for (genvar i = 0; i < 2; i++) begin : gen_info
    logic exp_zero;
    logic exp_ones;
    logic man_zero;

    assign exp_zero = (operands_i[i].exponent == '0);
    assign exp_ones = (operands_i[i].exponent == '1);
    assign man_zero = (operands_i[i].mantissa == '0);

    assign info_o[i].is_normal    = !exp_zero && !exp_ones;
    assign info_o[i].is_subnormal = exp_zero && !man_zero;
    assign info_o[i].is_zero      = exp_zero && man_zero;
    assign info_o[i].is_inf       = exp_ones && man_zero;
    assign info_o[i].is_nan       = exp_ones && !man_zero;
    // Quiet bit clear marks a signalling NaN
    assign info_o[i].is_signalling = exp_ones && !man_zero &&
                                     !operands_i[i].mantissa[fp_fmt_pkg::MAN_BITS-1];
  end

  // ---------------------------------------------------------------------
  // Class mask of operand A
  // ---------------------------------------------------------------------

  always_comb begin
    if (info_o[0].is_normal) begin
      class_mask_o = operands_i[0].sign ? fp_fmt_pkg::NEGNORM : fp_fmt_pkg::POSNORM;
    end else if (info_o[0].is_subnormal) begin
      class_mask_o = operands_i[0].sign ? fp_fmt_pkg::NEGSUBNORM : fp_fmt_pkg::POSSUBNORM;
    end else if (info_o[0].is_zero) begin
      class_mask_o = operands_i[0].sign ? fp_fmt_pkg::NEGZERO : fp_fmt_pkg::POSZERO;
    end else if (info_o[0].is_inf) begin
      class_mask_o = operands_i[0].sign ? fp_fmt_pkg::NEGINF : fp_fmt_pkg::POSINF;
    end else begin
      // Only NaNs are left here
      class_mask_o = info_o[0].is_signalling ? fp_fmt_pkg::SNAN : fp_fmt_pkg::QNAN;
    end
  end

endmodule

// File: hw/noncomp_pkg.sv
package noncomp_pkg;

  // ---------------------------------------------------------------------
  // Operation encoding
  // ---------------------------------------------------------------------

  typedef enum logic [1:0] {
    SGNJ,
    MINMAX,
    CMP,
    CLASSIFY
  } op_e;

  // Rounding-mode field, reused as sub-operation
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } subop_e;

  // Sign-injection variants
  typedef enum logic [1:0] {
    SEL_SGNJ,
    SEL_SGNJN,
    SEL_SGNJX,
    SEL_PASS
  } sgnj_sel_e;

  // Compare variants
  typedef enum logic [1:0] {
    CMP_LE,
    CMP_LT,
    CMP_EQ
  } cmp_sel_e;

  // Decoded controls toward the datapaths
  typedef struct packed {
    sgnj_sel_e sgnj_sel;
    logic      is_max;
    cmp_sel_e  cmp_sel;
    logic      invert;
    logic      ext_sign;
  } func_t;

  // Datapath result, 49 bits
  typedef struct packed {
    fp_fmt_pkg::fp_t        result;
    fp_fmt_pkg::status_t    status;
    logic                   extension_bit;
    fp_fmt_pkg::classmask_e class_mask;
    logic                   is_class;
  } result_t;

endpackage

// File: hw/fp_fmt_pkg.sv
package fp_fmt_pkg;

  // ---------------------------------------------------------------------
  // Binary32 format
  // ---------------------------------------------------------------------

  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;
  localparam int unsigned FP_WIDTH = 1 + EXP_BITS + MAN_BITS;

  // Operand fields, sign on top
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Class bits derived per operand
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // One-hot classify result, bit order as in the RISC-V fclass encoding
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // IEEE exception flags
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Positive quiet NaN, only the top mantissa bit set
  localparam fp_t CANON_NAN = {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

endpackage
